//--- src/cache_geom_pkg.sv
package cache_geom_pkg;

    ////////////////////////////////////////////////////////////
    // Address and data geometry
    ////////////////////////////////////////////////////////////

    // Processor and memory address
    localparam int addr_width = 32;
    // Processor data word
    localparam int word_width = 64;
    // One cache line, also the memory bus data width
    localparam int line_width = 256;

    // Address split, tag above index above byte offset
    localparam int offset_width = 5;
    localparam int index_width = 6;
    localparam int tag_width = addr_width - index_width - offset_width;

    localparam int num_sets = 1 << index_width;

    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;
    } addr_fields_t;

    // Raw view at the port, field view for line addresses
    typedef union packed {
        logic [addr_width-1:0] raw;
        addr_fields_t          fields;
    } cache_addr_u;

    // Stored per set and way
    typedef struct packed {
        logic                 dirty;
        logic                 valid;
        logic [tag_width-1:0] tag;
    } tag_entry_t;

    typedef logic [line_width-1:0] line_t;
    typedef logic [word_width-1:0] word_t;

endpackage

//--- src/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Controller encodings
    ////////////////////////////////////////////////////////////

    // Main controller states
    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_lookup  = 3'd1,
        st_miss    = 3'd2,
        st_replace = 3'd3,
        st_refill  = 3'd4,
        st_write   = 3'd5
    } state_t;

    // Access size on the processor port
    localparam logic [1:0] len_byte = 2'd0;
    localparam logic [1:0] len_half = 2'd1;
    localparam logic [1:0] len_word = 2'd2;
    localparam logic [1:0] len_dword = 2'd3;

endpackage

//--- src/cache_fsm.sv
`timescale 1ns/1ps

module cache_fsm (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      valid_in,
    input  logic                                      write,
    input  cache_geom_pkg::cache_addr_u               addr,
    input  cache_geom_pkg::word_t                     data_in,
    input  logic [1:0]                                len,
    input  logic                                      hit,
    input  logic                                      victim_dirty,
    input  logic [cache_geom_pkg::tag_width-1:0]      victim_tag,
    input  logic                                      r_rdy,
    input  logic                                      w_rdy,
    input  logic                                      re_valid,
    output cache_ctrl_pkg::state_t                    state,
    output cache_geom_pkg::cache_addr_u               req_addr,
    output cache_geom_pkg::word_t                     req_data,
    output logic [1:0]                                req_len,
    output logic                                      req_write,
    output logic                                      victim_way,
    output logic                                      addr_ok,
    output logic                                      data_ok,
    output logic                                      r_req,
    output logic                                      w_req,
    output logic [cache_geom_pkg::addr_width-1:0]     r_addr,
    output logic [cache_geom_pkg::addr_width-1:0]     w_addr
);

    cache_ctrl_pkg::state_t state_next;
    cache_geom_pkg::cache_addr_u wb_addr;
    cache_geom_pkg::cache_addr_u rd_addr;
    logic accept;

    ////////////////////////////////////////////////////////////
    // Processor handshake
    ////////////////////////////////////////////////////////////

    // Ready in idle, or while a read hit finishes
    assign addr_ok = (state == cache_ctrl_pkg::st_idle)
        || ((state == cache_ctrl_pkg::st_lookup) && hit && !req_write);
    assign accept = valid_in && addr_ok;

    // Read data from a hit or straight off the refill
    assign data_ok = !req_write
        && (((state == cache_ctrl_pkg::st_lookup) && hit)
        || ((state == cache_ctrl_pkg::st_refill) && re_valid));

    always_comb begin
        state_next = state;
        case (state)
            cache_ctrl_pkg::st_idle: begin
                if (valid_in) begin
                    state_next = cache_ctrl_pkg::st_lookup;
                end
            end
            cache_ctrl_pkg::st_lookup: begin
                if (!hit) begin
                    state_next = cache_ctrl_pkg::st_miss;
                end else if (req_write) begin
                    state_next = cache_ctrl_pkg::st_write;
                end else if (!valid_in) begin
                    state_next = cache_ctrl_pkg::st_idle;
                end
            end
            // Clean victims skip the write-back
            cache_ctrl_pkg::st_miss: begin
                if (w_rdy || !victim_dirty) begin
                    state_next = cache_ctrl_pkg::st_replace;
                end
            end
            cache_ctrl_pkg::st_replace: begin
                if (r_rdy) begin
                    state_next = cache_ctrl_pkg::st_refill;
                end
            end
            cache_ctrl_pkg::st_refill: begin
                if (re_valid) begin
                    state_next = cache_ctrl_pkg::st_idle;
                end
            end
            default: state_next = cache_ctrl_pkg::st_idle;
        endcase
    end

    // State and replacement toggle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_ctrl_pkg::st_idle;
            victim_way <= 1'b0;
        end else begin
            state <= state_next;
            if (state == cache_ctrl_pkg::st_lookup) begin
                victim_way <= ~victim_way;
            end
        end
    end

    // Request latch
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= addr;
            req_data <= data_in;
            req_len <= len;
            req_write <= write;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory bus requests
    ////////////////////////////////////////////////////////////

    // Line-aligned addresses built from the field view
    always_comb begin
        wb_addr = '0;
        wb_addr.fields.tag = victim_tag;
        wb_addr.fields.index = req_addr.fields.index;
        rd_addr = req_addr;
        rd_addr.fields.offset = '0;
    end

    assign w_addr = wb_addr.raw;
    assign r_addr = rd_addr.raw;
    assign w_req = (state == cache_ctrl_pkg::st_miss) && victim_dirty;
    assign r_req = state == cache_ctrl_pkg::st_replace;

endmodule

//--- src/tag_array.sv
`timescale 1ns/1ps

module tag_array (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [cache_geom_pkg::index_width-1:0] index,
    input  cache_ctrl_pkg::state_t                state,
    input  cache_geom_pkg::cache_addr_u           req_addr,
    input  logic                                  req_write,
    input  logic                                  victim_way,
    input  logic                                  re_valid,
    output logic                                  hit,
    output logic                                  hit_way,
    output logic                                  victim_dirty,
    output logic [cache_geom_pkg::tag_width-1:0]  victim_tag
);

    logic [cache_geom_pkg::tag_width-1:0] tag_mem [2][cache_geom_pkg::num_sets];
    logic [cache_geom_pkg::num_sets-1:0] valid_bits [2];
    logic [cache_geom_pkg::num_sets-1:0] dirty_bits [2];
    logic [cache_geom_pkg::tag_width-1:0] rd_tag [2];
    logic [1:0] rd_valid;
    logic [1:0] rd_dirty;
    cache_geom_pkg::tag_entry_t rd_entry [2];
    cache_geom_pkg::tag_entry_t held_entry [2];
    logic [1:0] way_hit;
    logic hit_way_q;
    logic refill_we;
    logic write_we;

    assign refill_we = (state == cache_ctrl_pkg::st_refill) && re_valid;
    assign write_we = state == cache_ctrl_pkg::st_write;

    // Tag field storage
    always_ff @(posedge clk) begin
        if (refill_we) begin
            tag_mem[victim_way][index] <= req_addr.fields.tag;
        end
        for (int w = 0; w < 2; w++) begin
            rd_tag[w] <= tag_mem[w][index];
        end
    end

    // Valid and dirty flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < 2; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
            end
            rd_valid <= '0;
            rd_dirty <= '0;
            hit_way_q <= 1'b0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                rd_valid[w] <= valid_bits[w][index];
                rd_dirty[w] <= dirty_bits[w][index];
            end
            // New line is dirty at once on a write miss
            if (refill_we) begin
                valid_bits[victim_way][index] <= 1'b1;
                dirty_bits[victim_way][index] <= req_write;
            end
            if (write_we) begin
                dirty_bits[hit_way_q][index] <= 1'b1;
            end
            if (state == cache_ctrl_pkg::st_lookup) begin
                hit_way_q <= way_hit[1];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Hit compare and victim
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            rd_entry[w] = '{dirty: rd_dirty[w], valid: rd_valid[w], tag: rd_tag[w]};
            way_hit[w] = rd_entry[w].valid && (rd_entry[w].tag == req_addr.fields.tag);
        end
    end

    // Entries kept for the miss path
    always_ff @(posedge clk) begin
        if (state == cache_ctrl_pkg::st_lookup) begin
            held_entry <= rd_entry;
        end
    end

    assign hit = |way_hit;
    assign hit_way = (state == cache_ctrl_pkg::st_lookup) ? way_hit[1] : hit_way_q;
    assign victim_dirty = held_entry[victim_way].valid && held_entry[victim_way].dirty;
    assign victim_tag = held_entry[victim_way].tag;

endmodule

//--- src/data_array.sv
`timescale 1ns/1ps

module data_array (
    input  logic                                  clk,
    input  logic [cache_geom_pkg::index_width-1:0] index,
    input  logic                                  we,
    input  logic                                  way,
    input  cache_geom_pkg::line_t                 wdata,
    input  cache_geom_pkg::line_t                 wmask,
    output cache_geom_pkg::line_t                 rdata0,
    output cache_geom_pkg::line_t                 rdata1
);

    ////////////////////////////////////////////////////////////
    // Line storage, two ways by 64 sets
    ////////////////////////////////////////////////////////////

    cache_geom_pkg::line_t mem [2][cache_geom_pkg::num_sets];

    // Bit-masked write into one way
    always_ff @(posedge clk) begin
        if (we) begin
            mem[way][index] <= (wdata & wmask) | (mem[way][index] & ~wmask);
        end
    end

    // Both ways read every cycle
    always_ff @(posedge clk) begin
        rdata0 <= mem[0][index];
        rdata1 <= mem[1][index];
    end

endmodule

//--- src/line_merge.sv
`timescale 1ns/1ps

module line_merge (
    input  cache_geom_pkg::line_t                   line,
    input  logic [cache_geom_pkg::offset_width-1:0] offset,
    input  logic [1:0]                              len,
    input  cache_geom_pkg::word_t                   wdata,
    output cache_geom_pkg::word_t                   rword,
    output cache_geom_pkg::line_t                   merged,
    output cache_geom_pkg::line_t                   wmask
);

    cache_geom_pkg::line_t rd_shifted;
    cache_geom_pkg::line_t wr_shifted;
    cache_geom_pkg::line_t len_mask;
    logic [cache_geom_pkg::offset_width+2:0] bit_shift;

    // Byte offset in bits
    assign bit_shift = {offset, 3'b000};

    // Zeros shift in above the line end
    assign rd_shifted = line >> bit_shift;
    assign rword = rd_shifted[cache_geom_pkg::word_width-1:0];

    // Byte mask for the access size
    always_comb begin
        len_mask = '0;
        case (len)
            cache_ctrl_pkg::len_byte:  len_mask[7:0] = '1;
            cache_ctrl_pkg::len_half:  len_mask[15:0] = '1;
            cache_ctrl_pkg::len_word:  len_mask[31:0] = '1;
            cache_ctrl_pkg::len_dword: len_mask[63:0] = '1;
        endcase
    end

    // Bytes past the line end drop off
    assign wmask = len_mask << bit_shift;
    assign wr_shifted = cache_geom_pkg::line_t'(wdata) << bit_shift;
    assign merged = (wr_shifted & wmask) | (line & ~wmask);

endmodule

//--- src/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [cache_geom_pkg::addr_width-1:0]    addr,
    input  logic [cache_geom_pkg::word_width-1:0]    data_in,
    input  logic                                     valid_in,
    input  logic                                     write,
    input  logic [1:0]                               len,
    output logic                                     addr_ok,
    output logic                                     data_ok,
    output logic [cache_geom_pkg::word_width-1:0]    data_out,
    output logic                                     r_req,
    output logic [cache_geom_pkg::addr_width-1:0]    r_addr,
    input  logic                                     r_rdy,
    input  logic [cache_geom_pkg::line_width-1:0]    re_data,
    input  logic                                     re_valid,
    output logic                                     w_req,
    output logic [cache_geom_pkg::addr_width-1:0]    w_addr,
    output logic [cache_geom_pkg::line_width-1:0]    w_data,
    input  logic                                     w_rdy
);

    cache_geom_pkg::cache_addr_u in_addr;
    cache_geom_pkg::cache_addr_u req_addr;
    cache_geom_pkg::word_t req_data;
    cache_ctrl_pkg::state_t state;
    logic [1:0] req_len;
    logic req_write;
    logic victim_way;
    logic hit;
    logic hit_way;
    logic victim_dirty;
    logic [cache_geom_pkg::tag_width-1:0] victim_tag;
    logic [cache_geom_pkg::index_width-1:0] array_index;
    cache_geom_pkg::line_t rdata0;
    cache_geom_pkg::line_t rdata1;
    cache_geom_pkg::line_t line0_q;
    cache_geom_pkg::line_t line1_q;
    cache_geom_pkg::line_t src_line;
    cache_geom_pkg::line_t merged;
    cache_geom_pkg::line_t merge_mask;
    cache_geom_pkg::line_t dat_wdata;
    cache_geom_pkg::line_t dat_wmask;
    logic dat_we;
    logic dat_way;

    ////////////////////////////////////////////////////////////
    // Array addressing and data paths
    ////////////////////////////////////////////////////////////

    assign in_addr = addr;

    // Incoming index while a new request can arrive
    assign array_index = ((state == cache_ctrl_pkg::st_idle)
        || (state == cache_ctrl_pkg::st_lookup))
        ? in_addr.fields.index : req_addr.fields.index;

    // Hit line on lookup, memory line otherwise
    assign src_line = (state == cache_ctrl_pkg::st_lookup)
        ? (hit_way ? rdata1 : rdata0) : re_data;

    // Both ways held from lookup for the write-back
    always_ff @(posedge clk) begin
        if (state == cache_ctrl_pkg::st_lookup) begin
            line0_q <= rdata0;
            line1_q <= rdata1;
        end
    end

    assign w_data = victim_way ? line1_q : line0_q;

    // Data array write source
    always_comb begin
        dat_we = 1'b0;
        dat_way = victim_way;
        dat_wdata = merged;
        dat_wmask = merge_mask;
        case (state)
            cache_ctrl_pkg::st_refill: begin
                dat_we = re_valid;
                dat_wdata = req_write ? merged : re_data;
                dat_wmask = '1;
            end
            cache_ctrl_pkg::st_write: begin
                dat_we = 1'b1;
                dat_way = hit_way;
            end
            default: begin
                dat_we = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Submodules
    ////////////////////////////////////////////////////////////

    cache_fsm cache_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_in     (valid_in),
        .write        (write),
        .addr         (in_addr),
        .data_in      (data_in),
        .len          (len),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .r_rdy        (r_rdy),
        .w_rdy        (w_rdy),
        .re_valid     (re_valid),
        .state        (state),
        .req_addr     (req_addr),
        .req_data     (req_data),
        .req_len      (req_len),
        .req_write    (req_write),
        .victim_way   (victim_way),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .r_req        (r_req),
        .w_req        (w_req),
        .r_addr       (r_addr),
        .w_addr       (w_addr)
    );

    tag_array tag_array_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .index        (array_index),
        .state        (state),
        .req_addr     (req_addr),
        .req_write    (req_write),
        .victim_way   (victim_way),
        .re_valid     (re_valid),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    data_array data_array_inst (
        .clk    (clk),
        .index  (array_index),
        .we     (dat_we),
        .way    (dat_way),
        .wdata  (dat_wdata),
        .wmask  (dat_wmask),
        .rdata0 (rdata0),
        .rdata1 (rdata1)
    );

    line_merge line_merge_inst (
        .line   (src_line),
        .offset (req_addr.fields.offset),
        .len    (req_len),
        .wdata  (req_data),
        .rword  (data_out),
        .merged (merged),
        .wmask  (merge_mask)
    );

endmodule

//--- test/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  r_req,
    input  logic [cache_geom_pkg::addr_width-1:0] r_addr,
    output logic                                  r_rdy,
    output logic [cache_geom_pkg::line_width-1:0] re_data,
    output logic                                  re_valid,
    input  logic                                  w_req,
    input  logic [cache_geom_pkg::addr_width-1:0] w_addr,
    input  logic [cache_geom_pkg::line_width-1:0] w_data,
    output logic                                  w_rdy
);

    // Backing store, one entry per line written back
    logic [cache_geom_pkg::line_width-1:0] store [logic [31:0]];
    logic [31:0] pend_addr;
    logic pending;
    int delay;

    // Initial image, every byte folded from its full address
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic logic [255:0] line_at(input logic [31:0] base);
        logic [255:0] l;
        if (store.exists(base)) begin
            l = store[base];
        end else begin
            for (int i = 0; i < 32; i++) begin
                l[8*i +: 8] = fill_byte(base + 32'(i));
            end
        end
        return l;
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus responses with random delays
    ////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_rdy <= 1'b0;
            w_rdy <= 1'b0;
            re_valid <= 1'b0;
            re_data <= '0;
            pending <= 1'b0;
            pend_addr <= '0;
            delay <= 0;
        end else begin
            re_valid <= 1'b0;
            w_rdy <= ($urandom_range(0, 2) == 0);
            // Victim line lands in the store
            if (w_req && w_rdy) begin
                store[w_addr] = w_data;
            end
            if (!pending) begin
                r_rdy <= ($urandom_range(0, 2) == 0);
                // Read taken, answer after a few cycles
                if (r_req && r_rdy) begin
                    pending <= 1'b1;
                    pend_addr <= r_addr;
                    delay <= int'($urandom_range(0, 4));
                    r_rdy <= 1'b0;
                end
            end else if (delay > 0) begin
                delay <= delay - 1;
            end else begin
                re_valid <= 1'b1;
                re_data <= line_at(pend_addr);
                pending <= 1'b0;
            end
        end
    end

endmodule

//--- test/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    logic clk = 1'b0;
    logic rst_n;
    logic [31:0] addr;
    logic [63:0] data_in;
    logic valid_in;
    logic write;
    logic [1:0] len;
    logic addr_ok;
    logic data_ok;
    logic [63:0] data_out;
    logic r_req;
    logic [31:0] r_addr;
    logic r_rdy;
    logic [255:0] re_data;
    logic re_valid;
    logic w_req;
    logic [31:0] w_addr;
    logic [255:0] w_data;
    logic w_rdy;

    // Processor view of memory, bytes written so far
    logic [7:0] ref_mem [logic [31:0]];
    logic [20:0] tag_pool [4] = '{21'h00001, 21'h00a5c, 21'h1f0f0, 21'h12345};
    logic [5:0] set_pool [2] = '{6'd3, 6'd40};
    string test_name;
    int errors = 0;
    int checks = 0;
    int test_errors = 0;
    logic [31:0] cur_addr;
    logic cur_write;
    logic prev_r_req, prev_r_rdy, prev_w_req, prev_w_rdy;
    logic [31:0] prev_r_addr, prev_w_addr;
    logic [255:0] prev_w_data;

    always #10 clk = ~clk;

    cache_top cache_top_inst (
        .clk(clk), .rst_n(rst_n), .addr(addr), .data_in(data_in), .valid_in(valid_in),
        .write(write), .len(len), .addr_ok(addr_ok), .data_ok(data_ok), .data_out(data_out),
        .r_req(r_req), .r_addr(r_addr), .r_rdy(r_rdy), .re_data(re_data), .re_valid(re_valid),
        .w_req(w_req), .w_addr(w_addr), .w_data(w_data), .w_rdy(w_rdy)
    );

    mem_model mem_model_inst (
        .clk(clk), .rst_n(rst_n), .r_req(r_req), .r_addr(r_addr), .r_rdy(r_rdy),
        .re_data(re_data), .re_valid(re_valid), .w_req(w_req), .w_addr(w_addr),
        .w_data(w_data), .w_rdy(w_rdy)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Same image the memory starts from
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
    endfunction

    function automatic logic [255:0] ref_line(input logic [31:0] base);
        logic [255:0] l;
        for (int i = 0; i < 32; i++) begin
            l[8*i +: 8] = ref_byte(base + 32'(i));
        end
        return l;
    endfunction

    // Shifted read, zero past the line end
    function automatic logic [63:0] expected_word(input logic [31:0] a);
        logic [63:0] w;
        w = '0;
        for (int i = 0; i < 8; i++) begin
            if (int'(a[4:0]) + i < 32) begin
                w[8*i +: 8] = ref_byte(a + 32'(i));
            end
        end
        return w;
    endfunction

    // Few tags over two sets, so ways get evicted
    function automatic logic [31:0] pick_addr();
        return {tag_pool[$urandom_range(0, 3)], set_pool[$urandom_range(0, 1)],
            5'($urandom_range(0, 31))};
    endfunction

    task automatic check_value(input logic [255:0] exp, input logic [255:0] act);
        checks++;
        assert (exp == act) else begin
            $display("Error %s: expected %0h actual %0h", test_name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Test %s: %s", test_name, what);
            errors++;
            test_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus monitor
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n) begin
            if (prev_r_req && !prev_r_rdy) begin
                check_true(r_req && (r_addr == prev_r_addr), "read request moved while stalled");
            end
            if (prev_w_req && !prev_w_rdy) begin
                check_true(w_req && (w_addr == prev_w_addr) && (w_data == prev_w_data),
                    "write-back request moved while stalled");
            end
            // Read data strobe belongs to reads only
            if (data_ok && cur_write) begin
                check_true(1'b0, "data_ok pulsed during a write");
            end
            // Aligned address of the pending request
            if (r_req && r_rdy) begin
                check_value({cur_addr[31:5], 5'b0}, r_addr);
            end
            if (w_req && w_rdy) begin
                check_true(w_addr[4:0] == 5'b0, "write-back address not line aligned");
                check_value(ref_line(w_addr), w_data);
            end
            if (re_valid && !cur_write) begin
                check_value(ref_line({cur_addr[31:5], 5'b0}), re_data);
            end
        end
        prev_r_req <= r_req;
        prev_r_rdy <= r_rdy;
        prev_r_addr <= r_addr;
        prev_w_req <= w_req;
        prev_w_rdy <= w_rdy;
        prev_w_addr <= w_addr;
        prev_w_data <= w_data;
    end

    ////////////////////////////////////////////////////////////
    // Processor side
    ////////////////////////////////////////////////////////////

    // Counts falling edges until the flag shows
    task automatic wait_flag(input logic use_data_ok, output int cycles);
        logic seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            seen = use_data_ok ? data_ok : addr_ok;
            if (!seen && cycles > 200) begin
                $display("Timeout in %s waiting for %s", test_name,
                    use_data_ok ? "data_ok" : "addr_ok");
                $display("Simulation failed");
                $finish;
            end
        end
    endtask

    task automatic access(input logic wr, input logic [31:0] a, input logic [1:0] l,
            input logic [63:0] d, input logic expect_hit);
        int cycles;
        logic [63:0] exp_word;
        cur_addr = a;
        cur_write = wr;
        addr <= a;
        write <= wr;
        len <= l;
        data_in <= d;
        valid_in <= 1'b1;
        wait_flag(1'b0, cycles);
        @(posedge clk);
        valid_in <= 1'b0;
        if (wr) begin
            for (int i = 0; i < (1 << l); i++) begin
                if (int'(a[4:0]) + i < 32) begin
                    ref_mem[a + 32'(i)] = d[8*i +: 8];
                end
            end
            wait_flag(1'b0, cycles);
            // Idle again two edges after acceptance
            if (expect_hit) begin
                check_true(cycles == 3, "write hit did not finish in two cycles");
            end
        end else begin
            exp_word = expected_word(a);
            wait_flag(1'b1, cycles);
            check_value(256'(exp_word), 256'(data_out));
            // One cycle after acceptance leaves room for no refill
            if (expect_hit) begin
                check_true((cycles == 1) && !r_req, "read of a resident line missed");
            end
        end
        @(posedge clk);
    endtask

    task automatic end_test();
        $display("Test %s finished, %0d errors", test_name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        logic [31:0] a;
        void'($urandom(45807));
        rst_n = 1'b0;
        addr = '0;
        data_in = '0;
        valid_in = 1'b0;
        write = 1'b0;
        len = 2'd0;
        cur_addr = '0;
        cur_write = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "reset_state";
        @(negedge clk);
        check_true(!data_ok && !r_req && !w_req && addr_ok, "outputs not idle after reset");
        @(posedge clk);
        end_test();

        test_name = "read_hit";
        for (int n = 0; n < 8; n++) begin
            a = pick_addr();
            access(1'b0, a, 2'd3, 64'd0, 1'b0);
            access(1'b0, {a[31:5], 5'($urandom_range(0, 31))}, 2'd3, 64'd0, 1'b1);
        end
        end_test();

        test_name = "write_hit";
        for (int n = 0; n < 12; n++) begin
            a = pick_addr();
            access(1'b0, a, 2'd3, 64'd0, 1'b0);
            access(1'b1, {a[31:5], 5'($urandom_range(0, 31))}, 2'(n % 4),
                {$urandom, $urandom}, 1'b1);
            access(1'b0, {a[31:5], 5'($urandom_range(0, 31))}, 2'd3, 64'd0, 1'b1);
        end
        end_test();

        test_name = "random_traffic";
        for (int n = 0; n < 400; n++) begin
            access(1'($urandom_range(0, 1)), pick_addr(), 2'($urandom_range(0, 3)),
                {$urandom, $urandom}, 1'b0);
        end
        end_test();

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
src/cache_geom_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_fsm.sv
src/tag_array.sv
src/data_array.sv
src/line_merge.sv
src/cache_top.sv
test/mem_model.sv
test/cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
